//--- hw/commit_tracer_consts.svh
`ifndef COMMIT_TRACER_CONSTS_SVH
`define COMMIT_TRACER_CONSTS_SVH

// ========================================
// Core interface widths
// ========================================

`define VADDR_W 39     // Sv39 virtual address
`define INSTR_W 32
`define DWORD_W 64     // Register data and interrupt cause
`define REG_ADDR_W 5   // Integer register file index

// ========================================
// Tracer timing and sizing
// ========================================

// Decode info runs ahead of commit by this many cycles
`define DECODE_DELAY 3

`define FIFO_DEPTH 8
`define FIFO_PTR_W 3   // Must cover FIFO_DEPTH entries

// Longest wait for a write-back before the record is forced out
`define WB_TIMEOUT 16

`define CNT_W 32       // Retired counter and wait timer

`endif

//--- hw/core_if_pkg.sv
`default_nettype none

`include "commit_tracer_consts.svh"

package core_if_pkg;

  // ========================================
  // Plain vectors seen on the core side
  // ========================================

  typedef logic [`VADDR_W-1:0] vaddr_t;
  typedef logic [`INSTR_W-1:0] instr_t;
  typedef logic [`DWORD_W-1:0] dword_t;       // Register data or interrupt cause
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // Subset of the back-end decode word that the tracer looks at
  typedef struct packed {
    logic irf_w_v;                            // Writes an integer register
    logic long_v;                             // Goes down the long-latency pipe
  } decode_s;

  // One FIFO word, captured on a commit or an interrupt
  typedef struct packed {
    logic   commit_v;
    vaddr_t pc;
    instr_t instr;
    logic   wb_v;                             // Record must wait for write-back data
    logic   interrupt_v;
    dword_t cause;
  } commit_entry_s;

endpackage

`default_nettype wire

//--- hw/trace_pkg.sv
`default_nettype none

package trace_pkg;

  typedef enum logic [0:0] {
    e_step,                                   // Instruction retired
    e_trap                                    // Interrupt taken
  } rec_kind_e;

  // Record handed to the checker or logger
  typedef struct packed {
    rec_kind_e           kind;
    core_if_pkg::vaddr_t pc;
    core_if_pkg::instr_t instr;
    core_if_pkg::dword_t wdata;               // Zero when nothing was written back
    core_if_pkg::dword_t cause;               // Only meaningful for traps
    logic                timeout;             // Write-back never showed up
  } retire_rec_s;

  // Retirement FSM
  typedef enum logic [0:0] {
    e_idle,
    e_wait_wb
  } retire_state_e;

endpackage

`default_nettype wire

//--- hw/decode_delay_line.sv
`default_nettype none

`include "commit_tracer_consts.svh"

module decode_delay_line (
  input  wire                  clk_i,
  input  wire                  arst_n_i,
  input  core_if_pkg::decode_s decode_i,
  output core_if_pkg::decode_s decode_o
);

  // Stage 0 is the youngest
  core_if_pkg::decode_s stage_r [`DECODE_DELAY];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `DECODE_DELAY; i++) begin
        stage_r[i] <= '0;
      end
    end else begin
      stage_r[0] <= decode_i;
      for (int i = 1; i < `DECODE_DELAY; i++) begin
        stage_r[i] <= stage_r[i-1];
      end
    end
  end

  // Lines up with the commit of the same instruction
  assign decode_o = stage_r[`DECODE_DELAY-1];

endmodule

`default_nettype wire

//--- hw/commit_fifo.sv
`default_nettype none

`include "commit_tracer_consts.svh"

module commit_fifo (
  input  wire                        clk_i,
  input  wire                        arst_n_i,
  input  wire                        push_i,
  input  core_if_pkg::commit_entry_s entry_i,
  input  wire                        pop_i,
  output core_if_pkg::commit_entry_s head_o,
  output logic                       head_v_o,
  output logic                       overflow_o
);

  typedef logic [`FIFO_PTR_W-1:0] ptr_t;
  typedef logic [`FIFO_PTR_W:0] occ_t;       // One extra bit to tell full from empty

  core_if_pkg::commit_entry_s mem [`FIFO_DEPTH];

  ptr_t rd_ptr_r;
  ptr_t wr_ptr_r;
  occ_t occ_r;
  logic full;
  logic do_push;
  logic do_pop;

  assign full     = (occ_r == occ_t'(`FIFO_DEPTH));
  assign head_v_o = (occ_r != '0);

  assign do_pop  = pop_i & head_v_o;
  assign do_push = push_i & (~full | do_pop); // A pop frees the slot in the same cycle

  // ========================================
  // Storage
  // ========================================

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_r] <= entry_i;
    end
  end

  assign head_o = mem[rd_ptr_r];

  // ========================================
  // Pointers, occupancy and overflow
  // ========================================

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_r   <= '0;
      wr_ptr_r   <= '0;
      occ_r      <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_r <= (wr_ptr_r == ptr_t'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_r <= (rd_ptr_r == ptr_t'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   occ_r <= occ_r + 1'b1;
        2'b01:   occ_r <= occ_r - 1'b1;
        default: occ_r <= occ_r;              // Both or neither leave it unchanged
      endcase
      if (push_i && !do_push) begin
        overflow_o <= 1'b1;                   // Entry lost, stays set until reset
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/retire_fsm.sv
`default_nettype none

module retire_fsm (
  input  wire                        clk_i,
  input  wire                        arst_n_i,
  input  core_if_pkg::commit_entry_s head_i,
  input  wire                        head_v_i,
  input  wire                        rd_w_v_i,
  input  core_if_pkg::dword_t        rd_data_i,
  input  wire                        timeout_i,
  output logic                       pop_o,
  output logic                       wait_en_o,
  output logic                       trace_v_o,
  output trace_pkg::retire_rec_s     trace_o
);

  trace_pkg::retire_state_e state_r;
  trace_pkg::retire_state_e state_n;
  trace_pkg::retire_rec_s   rec;
  logic                     is_trap;
  logic                     wb_hit;

  assign is_trap = head_i.interrupt_v;
  assign wb_hit  = ~is_trap & head_i.wb_v & rd_w_v_i;

  // ========================================
  // Next state and pop decision
  // ========================================

  always_comb begin
    state_n = state_r;
    pop_o   = 1'b0;
    case (state_r)
      trace_pkg::e_idle: begin
        if (head_v_i) begin
          if (is_trap || !head_i.wb_v || rd_w_v_i) begin
            pop_o = 1'b1;                     // Retires right away
          end else begin
            state_n = trace_pkg::e_wait_wb;
          end
        end
      end
      trace_pkg::e_wait_wb: begin
        if (rd_w_v_i || timeout_i) begin
          pop_o   = 1'b1;
          state_n = trace_pkg::e_idle;
        end
      end
      default: state_n = trace_pkg::e_idle;
    endcase
  end

  assign wait_en_o = (state_r == trace_pkg::e_wait_wb);

  // Record for the head, only used when it pops
  always_comb begin
    rec.kind    = is_trap ? trace_pkg::e_trap : trace_pkg::e_step;
    rec.pc      = head_i.pc;
    rec.instr   = head_i.instr;
    rec.wdata   = wb_hit ? rd_data_i : '0;
    rec.cause   = is_trap ? head_i.cause : '0;
    rec.timeout = ~is_trap & head_i.wb_v & ~rd_w_v_i; // Can only pop this way on timeout
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r   <= trace_pkg::e_idle;
      trace_v_o <= 1'b0;
    end else begin
      state_r   <= state_n;
      trace_v_o <= pop_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      trace_o <= rec;
    end
  end

endmodule

`default_nettype wire

//--- hw/retire_counters.sv
`default_nettype none

`include "commit_tracer_consts.svh"

module retire_counters (
  input  wire                    clk_i,
  input  wire                    arst_n_i,
  input  wire                    wait_en_i,
  input  wire                    trace_v_i,
  input  trace_pkg::retire_rec_s trace_i,
  output logic                   timeout_o,
  output logic [`CNT_W-1:0]      retired_cnt_o
);

  logic [`CNT_W-1:0] wait_cnt_r;

  // ========================================
  // Write-back wait timer
  // ========================================

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wait_cnt_r <= '0;
    end else if (wait_en_i) begin
      wait_cnt_r <= wait_cnt_r + 1'b1;
    end else begin
      wait_cnt_r <= '0;                       // Fresh start for the next wait
    end
  end

  assign timeout_o = (wait_cnt_r == `CNT_W'(`WB_TIMEOUT));

  // Traps are not counted as retired instructions
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      retired_cnt_o <= '0;
    end else if (trace_v_i && trace_i.kind == trace_pkg::e_step) begin
      retired_cnt_o <= retired_cnt_o + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/commit_tracer.sv
`default_nettype none

`include "commit_tracer_consts.svh"

module commit_tracer (
  input  wire                    clk_i,
  input  wire                    arst_n_i,
  input  core_if_pkg::decode_s   decode_i,
  input  wire                    commit_v_i,
  input  core_if_pkg::vaddr_t    commit_pc_i,
  input  core_if_pkg::instr_t    commit_instr_i,
  input  wire                    rd_w_v_i,
  input  core_if_pkg::reg_addr_t rd_addr_i,      // Part of the core's port set, not needed here
  input  core_if_pkg::dword_t    rd_data_i,
  input  wire                    interrupt_v_i,
  input  core_if_pkg::dword_t    cause_i,
  output logic                   trace_v_o,
  output trace_pkg::retire_rec_s trace_o,
  output logic [`CNT_W-1:0]      retired_cnt_o,
  output logic                   overflow_o
);

  core_if_pkg::decode_s       aligned_decode;
  core_if_pkg::commit_entry_s entry;
  core_if_pkg::commit_entry_s head;
  logic                       head_v;
  logic                       pop;
  logic                       wait_en;
  logic                       timeout;

  decode_delay_line u_delay (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .decode_i (decode_i),
    .decode_o (aligned_decode)
  );

  // ========================================
  // FIFO entry capture
  // ========================================

  assign entry.commit_v    = commit_v_i;
  assign entry.pc          = commit_pc_i;
  assign entry.instr       = commit_instr_i;
  assign entry.wb_v        = aligned_decode.irf_w_v | aligned_decode.long_v;
  assign entry.interrupt_v = interrupt_v_i;
  assign entry.cause       = cause_i;

  commit_fifo u_fifo (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .push_i     (commit_v_i | interrupt_v_i),
    .entry_i    (entry),
    .pop_i      (pop),
    .head_o     (head),
    .head_v_o   (head_v),
    .overflow_o (overflow_o)
  );

  retire_fsm u_fsm (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .head_i    (head),
    .head_v_i  (head_v),
    .rd_w_v_i  (rd_w_v_i),
    .rd_data_i (rd_data_i),
    .timeout_i (timeout),
    .pop_o     (pop),
    .wait_en_o (wait_en),
    .trace_v_o (trace_v_o),
    .trace_o   (trace_o)
  );

  retire_counters u_cnt (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .wait_en_i     (wait_en),
    .trace_v_i     (trace_v_o),
    .trace_i       (trace_o),
    .timeout_o     (timeout),
    .retired_cnt_o (retired_cnt_o)
  );

endmodule

`default_nettype wire

//--- dv/commit_tracer_asserts.sv
`default_nettype none

module commit_tracer_asserts (
  input wire clk_i,
  input wire arst_n_i,
  input wire pop_i,
  input wire head_v_i,
  input wire trace_v_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // ========================================
  // Handshake and FIFO invariants
  // ========================================

  pop_needs_entry: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) pop_i |-> head_v_i
  ) else $error("pop with an empty FIFO");

  // Each strobe stands for exactly one entry that was really at the head
  strobe_from_entry: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) trace_v_i |-> $past(pop_i && head_v_i)
  ) else $error("record strobe without a pop of a valid entry in the cycle before");

  quiet_in_reset: assert property (
    @(posedge clk_i) !arst_n_i |-> !trace_v_i
  ) else $error("record strobe during reset");

endmodule

bind retire_fsm commit_tracer_asserts u_fsm_asserts (
  .clk_i     (clk_i),
  .arst_n_i  (arst_n_i),
  .pop_i     (pop_o),
  .head_v_i  (head_v_i),
  .trace_v_i (trace_v_o)
);

// The FIFO has no strobe of its own
bind commit_fifo commit_tracer_asserts u_fifo_asserts (
  .clk_i     (clk_i),
  .arst_n_i  (arst_n_i),
  .pop_i     (pop_i),
  .head_v_i  (head_v_o),
  .trace_v_i (1'b0)
);

`default_nettype wire

//--- dv/commit_tracer_tb.sv
`default_nettype none

`include "commit_tracer_consts.svh"

module commit_tracer_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RUN_CYCLES    = 260;       // Rough sum of the six tests
  localparam int MARGIN_CYCLES = 200;

  logic                   clk = 1'b0;
  logic                   arst_n_i;
  core_if_pkg::decode_s   decode_i;
  logic                   commit_v_i;
  core_if_pkg::vaddr_t    commit_pc_i;
  core_if_pkg::instr_t    commit_instr_i;
  logic                   rd_w_v_i;
  core_if_pkg::reg_addr_t rd_addr_i;
  core_if_pkg::dword_t    rd_data_i;
  logic                   interrupt_v_i;
  core_if_pkg::dword_t    cause_i;
  logic                   trace_v_o;
  trace_pkg::retire_rec_s trace_o;
  logic [`CNT_W-1:0]      retired_cnt_o;
  logic                   overflow_o;

  trace_pkg::retire_rec_s exp_q[$];
  int                     wb_seq_q[$];      // Sequence numbers still waiting for write-back
  int                     popped;
  logic [`CNT_W-1:0]      exp_cnt;
  int                     seed = 32'h2926_8e36;

  commit_tracer dut (
    .clk_i          (clk),
    .arst_n_i       (arst_n_i),
    .decode_i       (decode_i),
    .commit_v_i     (commit_v_i),
    .commit_pc_i    (commit_pc_i),
    .commit_instr_i (commit_instr_i),
    .rd_w_v_i       (rd_w_v_i),
    .rd_addr_i      (rd_addr_i),
    .rd_data_i      (rd_data_i),
    .interrupt_v_i  (interrupt_v_i),
    .cause_i        (cause_i),
    .trace_v_o      (trace_v_o),
    .trace_o        (trace_o),
    .retired_cnt_o  (retired_cnt_o),
    .overflow_o     (overflow_o)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  initial begin
    #((RUN_CYCLES + MARGIN_CYCLES) * 20);
    stop_with_error("Watchdog expired because the run hung");
  end

  // ========================================
  // Reporting and compares
  // ========================================

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_rec(input trace_pkg::retire_rec_s got, input trace_pkg::retire_rec_s exp);
    if (got !== exp) begin
      stop_with_error($sformatf("error at %0d ns: record got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_cnt(input logic [`CNT_W-1:0] got, input logic [`CNT_W-1:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("error at %0d ns: retired count %0d expected %0d",
                                $time, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("error at %0d ns: flag %b expected %b", $time, got, exp));
    end
  endtask

  function automatic core_if_pkg::dword_t rand_dword();
    return {$random(seed), $random(seed)};
  endfunction

  // Outputs are stable at the falling edge
  initial begin
    forever begin
      @(negedge clk);
      if (arst_n_i && trace_v_o) begin
        if (exp_q.size() == 0) begin
          stop_with_error("A record appeared that no stimulus asked for");
        end
        check_rec(trace_o, exp_q[0]);
        if (exp_q[0].kind == trace_pkg::e_step) begin
          exp_cnt = exp_cnt + 1'b1;
        end
        void'(exp_q.pop_front());
        popped++;
      end
    end
  end

  // ========================================
  // Stimulus
  // ========================================

  // Decode goes out DECODE_DELAY cycles ahead of each commit, n commits back to back
  task automatic issue_instr(input int n, input logic [15:0] wb_mask, input int n_kept);
    core_if_pkg::vaddr_t    pcs [16];
    core_if_pkg::instr_t    instrs [16];
    trace_pkg::retire_rec_s rec;
    int                     j;
    for (int k = 0; k < n; k++) begin
      pcs[k]    = core_if_pkg::vaddr_t'(rand_dword());
      instrs[k] = core_if_pkg::instr_t'($random(seed));
    end
    for (int i = 0; i < n + `DECODE_DELAY; i++) begin
      decode_i   = '0;
      commit_v_i = 1'b0;
      if (i < n) begin
        decode_i.irf_w_v = wb_mask[i];
      end
      if (i >= `DECODE_DELAY) begin
        j              = i - `DECODE_DELAY;
        commit_v_i     = 1'b1;
        commit_pc_i    = pcs[j];
        commit_instr_i = instrs[j];
        if (j < n_kept) begin                 // Later ones are lost to overflow
          rec       = '0;
          rec.kind  = trace_pkg::e_step;
          rec.pc    = pcs[j];
          rec.instr = instrs[j];
          if (wb_mask[j]) begin
            wb_seq_q.push_back(popped + exp_q.size());
          end
          exp_q.push_back(rec);
        end
      end
      @(negedge clk);
    end
    decode_i   = '0;
    commit_v_i = 1'b0;
  endtask

  task automatic issue_wb(input core_if_pkg::dword_t data);
    trace_pkg::retire_rec_s rec;
    int                     idx;
    idx        = wb_seq_q.pop_front() - popped;
    rec        = exp_q[idx];
    rec.wdata  = data;
    exp_q[idx] = rec;
    rd_w_v_i   = 1'b1;
    rd_addr_i  = core_if_pkg::reg_addr_t'($random(seed));
    rd_data_i  = data;
    @(negedge clk);
    rd_w_v_i   = 1'b0;
  endtask

  // The oldest write-back is never sent
  task automatic expect_wb_timeout();
    trace_pkg::retire_rec_s rec;
    int                     idx;
    idx         = wb_seq_q.pop_front() - popped;
    rec         = exp_q[idx];
    rec.timeout = 1'b1;
    exp_q[idx]  = rec;
  endtask

  task automatic issue_irq(input core_if_pkg::dword_t cause);
    trace_pkg::retire_rec_s rec;
    rec            = '0;
    rec.kind       = trace_pkg::e_trap;
    rec.pc         = core_if_pkg::vaddr_t'(rand_dword());
    rec.instr      = core_if_pkg::instr_t'($random(seed));
    rec.cause      = cause;
    interrupt_v_i  = 1'b1;
    cause_i        = cause;
    commit_pc_i    = rec.pc;
    commit_instr_i = rec.instr;
    exp_q.push_back(rec);
    @(negedge clk);
    interrupt_v_i  = 1'b0;
  endtask

  task automatic wait_records(input int max_cycles);
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > max_cycles) begin
        stop_with_error("Expected records did not appear in time");
      end
    end
    @(negedge clk);
  endtask

  // ========================================
  // Tests
  // ========================================

  task automatic single_commit_latency();
    issue_instr(1, 16'h0000, 1);
    check_flag(trace_v_o, 1'b0);              // One cycle after commit
    @(negedge clk);
    check_flag(trace_v_o, 1'b1);
    wait_records(10);
    check_cnt(retired_cnt_o, `CNT_W'(1));
  endtask

  task automatic wb_ordering();
    int gap;
    issue_instr(3, 16'h0007, 3);
    for (int k = 0; k < 3; k++) begin
      gap = {$random(seed)} % 10 + 1;
      repeat (gap - 1) @(negedge clk);
      issue_wb(rand_dword());
    end
    wait_records(40);
    check_cnt(retired_cnt_o, exp_cnt);
  endtask

  task automatic trap_between_commits();
    logic [`CNT_W-1:0] cnt_before;
    cnt_before = exp_cnt;
    issue_instr(1, 16'h0000, 1);
    issue_irq(rand_dword());
    issue_instr(1, 16'h0000, 1);
    wait_records(20);
    check_cnt(retired_cnt_o, cnt_before + 2);
  endtask

  task automatic wb_timeout_recovery();
    issue_instr(1, 16'h0001, 1);
    expect_wb_timeout();
    issue_instr(1, 16'h0000, 1);
    wait_records(2 * `WB_TIMEOUT + 10);
    issue_instr(1, 16'h0001, 1);
    issue_wb(rand_dword());
    wait_records(20);
    check_cnt(retired_cnt_o, exp_cnt);
  endtask

  task automatic fifo_overflow();
    check_flag(overflow_o, 1'b0);
    issue_instr(9, 16'h0001, 8);
    check_flag(overflow_o, 1'b1);
    issue_wb(rand_dword());
    wait_records(30);
    check_cnt(retired_cnt_o, exp_cnt);
  endtask

  task automatic reset_mid_stream();
    issue_instr(2, 16'h0001, 2);
    arst_n_i = 1'b0;
    exp_q.delete();
    wb_seq_q.delete();
    popped   = 0;
    exp_cnt  = '0;
    repeat (2) @(negedge clk);
    check_flag(trace_v_o, 1'b0);
    check_flag(overflow_o, 1'b0);
    check_cnt(retired_cnt_o, '0);
    arst_n_i = 1'b1;
    @(negedge clk);
    issue_instr(1, 16'h0000, 1);
    wait_records(10);
    check_cnt(retired_cnt_o, `CNT_W'(1));
  endtask

  initial begin
    arst_n_i       = 1'b0;
    decode_i       = '0;
    commit_v_i     = 1'b0;
    commit_pc_i    = '0;
    commit_instr_i = '0;
    rd_w_v_i       = 1'b0;
    rd_addr_i      = '0;
    rd_data_i      = '0;
    interrupt_v_i  = 1'b0;
    cause_i        = '0;
    popped         = 0;
    exp_cnt        = '0;
    repeat (2) @(negedge clk);
    arst_n_i = 1'b1;
    @(negedge clk);
    single_commit_latency();
    wb_ordering();
    trap_between_commits();
    wb_timeout_recovery();
    fifo_overflow();
    reset_mid_stream();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- commit_tracer.f
+incdir+hw
hw/core_if_pkg.sv
hw/trace_pkg.sv
hw/decode_delay_line.sv
hw/commit_fifo.sv
hw/retire_fsm.sv
hw/retire_counters.sv
hw/commit_tracer.sv
dv/commit_tracer_asserts.sv
dv/commit_tracer_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = commit_tracer_tb
FILELIST = commit_tracer.f
OBJ_DIR  = obj_dir
PASS_MSG = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Pass only when the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
